// ==== hw/arf_pkg.sv ====
`default_nettype none

package arf_pkg;

   // architectural register selector and file depth
   localparam int reg_sel_w = 5;
   localparam int reg_num   = 32;

   // committed data word
   localparam int data_w = 32;

   // rename tag, indexes the rename buffer
   localparam int rrf_sel_w = 6;

   // two instructions, two sources each
   localparam int src_reads = 4;

   typedef logic [reg_sel_w-1:0] reg_sel_t;
   typedef logic [data_w-1:0]    data_t;
   typedef logic [rrf_sel_w-1:0] rrf_tag_t;

   // sources of one instruction
   typedef struct packed {
      reg_sel_t rs1;
      reg_sel_t rs2;
   } src_pair_t;

   // one source read result
   // tag only meaningful while busy is set
   typedef struct packed {
      data_t    data;
      rrf_tag_t tag;
      logic     busy;
   } operand_t;

   typedef struct packed {
      operand_t rs1;
      operand_t rs2;
   } operand_pair_t;

   // retire of one instruction from the rename buffer
   typedef struct packed {
      logic     en;
      reg_sel_t dst;
      data_t    data;
      rrf_tag_t tag;
   } commit_t;

   // dispatch of one instruction, dst gets a new producer
   typedef struct packed {
      logic     en;
      reg_sel_t dst;
      rrf_tag_t tag;
   } rename_set_t;

   // one busy bit per architectural register
   typedef logic [reg_num-1:0] busy_vec_t;

endpackage

`default_nettype wire

// ==== hw/reg_array.sv ====
`timescale 1ns/1ps
`default_nettype none

// register array, one entry per architectural register
// reads are combinational, writes land on the next edge
module reg_array #(
   parameter type entry_t  = arf_pkg::data_t,
   parameter int  num_read = 4
) (
   input  wire               clk,
   input  wire               reset,

   // read ports
   input  wire arf_pkg::reg_sel_t raddr [num_read],
   output entry_t            rdata [num_read],

   // write port 1
   input  wire               we1,
   input  wire arf_pkg::reg_sel_t waddr1,
   input  wire entry_t       wdata1,

   // write port 2, wins on address collision
   input  wire               we2,
   input  wire arf_pkg::reg_sel_t waddr2,
   input  wire entry_t       wdata2
);

   // storage
   entry_t mem [arf_pkg::reg_num];

   // all entries start at zero
   // so reg 0 reads zero as long as nobody writes it
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < arf_pkg::reg_num; i++) begin
            mem[i] <= '0;
         end
      end else begin
         if (we1) begin
            mem[waddr1] <= wdata1;
         end
         // port 2 scheduled last, so it overrides port 1
         if (we2) begin
            mem[waddr2] <= wdata2;
         end
      end
   end

   // read mux per port
   // no bypass of same-cycle writes
   always_comb begin
      for (int i = 0; i < num_read; i++) begin
         rdata[i] = mem[raddr[i]];
      end
   end

endmodule

`default_nettype wire

// ==== hw/commit_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// commit side decode
// turns two commit requests into data write enables and busy clears
module commit_unit (
   // commit requests
   input  wire arf_pkg::commit_t commit1,
   input  wire arf_pkg::commit_t commit2,

   // stored rename tag of each commit's dst
   // read from the tag array this cycle
   input  wire arf_pkg::rrf_tag_t cur_tag1,
   input  wire arf_pkg::rrf_tag_t cur_tag2,

   // data array write enables
   output wire data_we1,
   output wire data_we2,

   // busy clear requests to busy_vector
   output wire clear1,
   output wire clear2
);

   // dst not register 0
   wire dst_nz1;
   wire dst_nz2;

   // commit tag is still the newest producer
   wire tag_hit1;
   wire tag_hit2;

   assign dst_nz1 = (commit1.dst != '0);
   assign dst_nz2 = (commit2.dst != '0);

   // register 0 is hardwired zero, drop its writes
   assign data_we1 = commit1.en && dst_nz1;
   assign data_we2 = commit2.en && dst_nz2;

   // a renamed-again register keeps a newer tag
   // the older commit must not free it
   assign tag_hit1 = (commit1.tag == cur_tag1);
   assign tag_hit2 = (commit2.tag == cur_tag2);

   // data still goes in on a miss, only busy is kept
   assign clear1 = commit1.en && tag_hit1;
   assign clear2 = commit2.en && tag_hit2;

endmodule

`default_nettype wire

// ==== hw/busy_vector.sv ====
`timescale 1ns/1ps
`default_nettype none

// busy bit per architectural register
// set by dispatch, cleared by a tag-matched commit
module busy_vector (
   input  wire clk,
   input  wire reset,

   // dispatch requests, set busy
   input  wire arf_pkg::rename_set_t rename1,
   input  wire arf_pkg::rename_set_t rename2,

   // clear requests from commit_unit
   input  wire clear1,
   input  wire clear2,
   input  wire arf_pkg::reg_sel_t commit_reg1,
   input  wire arf_pkg::reg_sel_t commit_reg2,

   output arf_pkg::busy_vec_t busy
);

   // same-cycle rename hits the commit dst
   logic blk1;
   logic blk2;

   arf_pkg::busy_vec_t set_mask;
   arf_pkg::busy_vec_t clr_mask;

   // a new producer outranks the retiring one
   assign blk1 = (rename1.en && (rename1.dst == commit_reg1)) ||
                 (rename2.en && (rename2.dst == commit_reg1));
   assign blk2 = (rename1.en && (rename1.dst == commit_reg2)) ||
                 (rename2.en && (rename2.dst == commit_reg2));

   // one-hot masks per request, ored together
   always_comb begin
      set_mask = '0;
      clr_mask = '0;
      if (rename1.en) begin
         set_mask[rename1.dst] = 1'b1;
      end
      if (rename2.en) begin
         set_mask[rename2.dst] = 1'b1;
      end
      // blocked clears dropped here
      if (clear1 && !blk1) begin
         clr_mask[commit_reg1] = 1'b1;
      end
      if (clear2 && !blk2) begin
         clr_mask[commit_reg2] = 1'b1;
      end
   end

   // clears go last, only unblocked ones are left in the mask
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= '0;
      end else begin
         busy <= (busy | set_mask) & ~clr_mask;
      end
   end

endmodule

`default_nettype wire

// ==== hw/arf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// architectural register file plus rename table
// two instructions per cycle, four source reads
module arf_top (
   input  wire clk,
   input  wire reset,

   // source selectors, one pair per instruction
   input  wire arf_pkg::src_pair_t src1,
   input  wire arf_pkg::src_pair_t src2,

   // retire side
   input  wire arf_pkg::commit_t commit1,
   input  wire arf_pkg::commit_t commit2,

   // dispatch side
   input  wire arf_pkg::rename_set_t rename1,
   input  wire arf_pkg::rename_set_t rename2,

   // operands back to dispatch
   output wire arf_pkg::operand_pair_t opnd1,
   output wire arf_pkg::operand_pair_t opnd2
);

   // flat source list, order rs1_1 rs2_1 rs1_2 rs2_2
   wire arf_pkg::reg_sel_t src_sel [arf_pkg::src_reads];

   // tag reads, sources then the two commit dsts
   wire arf_pkg::reg_sel_t tag_sel [arf_pkg::src_reads + 2];

   arf_pkg::data_t    data_rd [arf_pkg::src_reads];
   arf_pkg::rrf_tag_t tag_rd  [arf_pkg::src_reads + 2];

   wire data_we1;
   wire data_we2;
   wire clear1;
   wire clear2;

   arf_pkg::busy_vec_t busy;

   wire arf_pkg::operand_t opnd [arf_pkg::src_reads];

   assign src_sel[0] = src1.rs1;
   assign src_sel[1] = src1.rs2;
   assign src_sel[2] = src2.rs1;
   assign src_sel[3] = src2.rs2;

   for (genvar g = 0; g < arf_pkg::src_reads; g++) begin : g_tag_src
      assign tag_sel[g] = src_sel[g];
   end
   // extra ports feed the commit tag check
   assign tag_sel[arf_pkg::src_reads]     = commit1.dst;
   assign tag_sel[arf_pkg::src_reads + 1] = commit2.dst;

   // committed data
   reg_array #(
      .entry_t  (arf_pkg::data_t),
      .num_read (arf_pkg::src_reads)
   ) data_array (
      .clk    (clk),
      .reset  (reset),
      .raddr  (src_sel),
      .rdata  (data_rd),
      .we1    (data_we1),
      .waddr1 (commit1.dst),
      .wdata1 (commit1.data),
      .we2    (data_we2),
      .waddr2 (commit2.dst),
      .wdata2 (commit2.data)
   );

   // newest producer tag per register, written at dispatch
   reg_array #(
      .entry_t  (arf_pkg::rrf_tag_t),
      .num_read (arf_pkg::src_reads + 2)
   ) tag_array (
      .clk    (clk),
      .reset  (reset),
      .raddr  (tag_sel),
      .rdata  (tag_rd),
      .we1    (rename1.en),
      .waddr1 (rename1.dst),
      .wdata1 (rename1.tag),
      .we2    (rename2.en),
      .waddr2 (rename2.dst),
      .wdata2 (rename2.tag)
   );

   commit_unit commit_unit (
      .commit1  (commit1),
      .commit2  (commit2),
      .cur_tag1 (tag_rd[arf_pkg::src_reads]),
      .cur_tag2 (tag_rd[arf_pkg::src_reads + 1]),
      .data_we1 (data_we1),
      .data_we2 (data_we2),
      .clear1   (clear1),
      .clear2   (clear2)
   );

   busy_vector busy_vector (
      .clk         (clk),
      .reset       (reset),
      .rename1     (rename1),
      .rename2     (rename2),
      .clear1      (clear1),
      .clear2      (clear2),
      .commit_reg1 (commit1.dst),
      .commit_reg2 (commit2.dst),
      .busy        (busy)
   );

   // operand assembly, busy bit picked by source selector
   for (genvar g = 0; g < arf_pkg::src_reads; g++) begin : g_opnd
      assign opnd[g] = '{data: data_rd[g], tag: tag_rd[g], busy: busy[src_sel[g]]};
   end

   assign opnd1 = '{rs1: opnd[0], rs2: opnd[1]};
   assign opnd2 = '{rs1: opnd[2], rs2: opnd[3]};

endmodule

`default_nettype wire

// ==== include/arf_ref_model.svh ====
`ifndef ARF_REF_MODEL_SVH
`define ARF_REF_MODEL_SVH

// reference state, mirrors the DUT storage
arf_pkg::data_t     m_data [arf_pkg::reg_num];
arf_pkg::rrf_tag_t  m_tag  [arf_pkg::reg_num];
arf_pkg::busy_vec_t m_busy;

// everything back to zero
function automatic void model_reset();
   for (int i = 0; i < arf_pkg::reg_num; i++) begin
      m_data[i] = '0;
      m_tag[i]  = '0;
   end
   m_busy = '0;
endfunction

// apply one cycle of requests
// tag match is taken against the state before this cycle
function automatic void model_update(input arf_pkg::commit_t c1, input arf_pkg::commit_t c2,
                                     input arf_pkg::rename_set_t r1,
                                     input arf_pkg::rename_set_t r2);
   logic clr1;
   logic clr2;
   clr1 = c1.en && (c1.tag == m_tag[c1.dst]);
   clr2 = c2.en && (c2.tag == m_tag[c2.dst]);
   // register 0 keeps zero data, port 2 applied last
   if (c1.en && (c1.dst != '0)) m_data[c1.dst] = c1.data;
   if (c2.en && (c2.dst != '0)) m_data[c2.dst] = c2.data;
   if (clr1) m_busy[c1.dst] = 1'b0;
   if (clr2) m_busy[c2.dst] = 1'b0;
   // sets after clears, so dispatch wins
   if (r1.en) begin
      m_tag[r1.dst]  = r1.tag;
      m_busy[r1.dst] = 1'b1;
   end
   if (r2.en) begin
      m_tag[r2.dst]  = r2.tag;
      m_busy[r2.dst] = 1'b1;
   end
endfunction

// expected operand for one selector
function automatic arf_pkg::operand_t model_read(input arf_pkg::reg_sel_t sel);
   return '{data: m_data[sel], tag: m_tag[sel], busy: m_busy[sel]};
endfunction

`endif

// ==== sim/arf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module arf_tb;

   logic clk = 1'b0;
   logic reset;
   arf_pkg::src_pair_t src1, src2;
   arf_pkg::commit_t commit1, commit2;
   arf_pkg::rename_set_t rename1, rename2;
   arf_pkg::operand_pair_t opnd1, opnd2;
   integer seed;

   `include "arf_ref_model.svh"

   arf_top dut (
      .clk     (clk),
      .reset   (reset),
      .src1    (src1),
      .src2    (src2),
      .commit1 (commit1),
      .commit2 (commit2),
      .rename1 (rename1),
      .rename2 (rename2),
      .opnd1   (opnd1),
      .opnd2   (opnd2)
   );

   // 8 ns period
   always #4 clk = ~clk;

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         $display("tests failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // all four sources against the model
   task automatic check_operands(input string name);
      arf_pkg::reg_sel_t sel [4];
      arf_pkg::operand_t act [4];
      logic [63:0] exp_v;
      logic [63:0] act_v;
      sel = '{src1.rs1, src1.rs2, src2.rs1, src2.rs2};
      act = '{opnd1.rs1, opnd1.rs2, opnd2.rs1, opnd2.rs2};
      for (int i = 0; i < 4; i++) begin
         exp_v = model_read(sel[i]);
         act_v = act[i];
         check_value($sformatf("%s src%0d", name, i), exp_v, act_v);
      end
   endtask

   // sample mid-cycle, then mirror the edge in the model
   task automatic tick(input string name);
      @(negedge clk);
      check_operands(name);
      @(posedge clk);
      model_update(commit1, commit2, rename1, rename2);
   endtask

   task automatic set_sources(input arf_pkg::reg_sel_t a, input arf_pkg::reg_sel_t b,
                              input arf_pkg::reg_sel_t c, input arf_pkg::reg_sel_t d);
      src1 <= '{rs1: a, rs2: b};
      src2 <= '{rs1: c, rs2: d};
   endtask

   task automatic put_commit(input int port, input arf_pkg::reg_sel_t dst,
                             input arf_pkg::data_t data, input arf_pkg::rrf_tag_t tag);
      arf_pkg::commit_t c;
      c = '{en: 1'b1, dst: dst, data: data, tag: tag};
      if (port == 1) commit1 <= c;
      else commit2 <= c;
   endtask

   task automatic put_rename(input int port, input arf_pkg::reg_sel_t dst,
                             input arf_pkg::rrf_tag_t tag);
      arf_pkg::rename_set_t r;
      r = '{en: 1'b1, dst: dst, tag: tag};
      if (port == 1) rename1 <= r;
      else rename2 <= r;
   endtask

   task automatic clear_requests();
      commit1 <= '0;
      commit2 <= '0;
      rename1 <= '0;
      rename2 <= '0;
   endtask

   // bounded wait for zeroed operands after reset release
   task automatic wait_reset_done();
      int n;
      n = 0;
      while (n < 20 && (opnd1 !== '0 || opnd2 !== '0)) begin
         @(negedge clk);
         n++;
      end
      if (opnd1 !== '0 || opnd2 !== '0) begin
         $display("timeout: operands did not read zero after reset");
         $display("tests failed");
         $fatal(1, "reset wait timed out");
      end
   endtask

   // narrow range, so ports collide often
   function automatic arf_pkg::reg_sel_t rand_reg();
      return arf_pkg::reg_sel_t'($random(seed) & 7);
   endfunction

   task automatic random_traffic(input int cycles);
      arf_pkg::commit_t c [2];
      arf_pkg::rename_set_t r [2];
      for (int n = 0; n < cycles; n++) begin
         set_sources(rand_reg(), rand_reg(), rand_reg(), rand_reg());
         for (int p = 0; p < 2; p++) begin
            c[p].en   = 1'($random(seed));
            c[p].dst  = rand_reg();
            c[p].data = $random(seed);
            // half the commits carry the live tag
            if ($random(seed) & 1) c[p].tag = m_tag[c[p].dst];
            else c[p].tag = arf_pkg::rrf_tag_t'($random(seed));
            r[p] = '{en: 1'($random(seed)), dst: rand_reg(),
                     tag: arf_pkg::rrf_tag_t'($random(seed))};
         end
         commit1 <= c[0];
         commit2 <= c[1];
         rename1 <= r[0];
         rename2 <= r[1];
         tick("random traffic");
      end
   endtask

   initial begin
      seed = 32'h9a52;
      reset = 1'b1;
      src1 = '0;
      src2 = '0;
      commit1 = '0;
      commit2 = '0;
      rename1 = '0;
      rename2 = '0;
      model_reset();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      wait_reset_done();
      @(posedge clk);
      // sweep every register once
      for (int r = 0; r < arf_pkg::reg_num; r += 4) begin
         set_sources(arf_pkg::reg_sel_t'(r), arf_pkg::reg_sel_t'(r + 1),
                     arf_pkg::reg_sel_t'(r + 2), arf_pkg::reg_sel_t'(r + 3));
         tick("after reset");
      end
      // commit data, reg 0 write dropped
      set_sources(5'd5, 5'd0, 5'd7, 5'd0);
      put_commit(1, 5'd5, 32'hdead_beef, 6'd0);
      put_commit(2, 5'd0, 32'h0bad_f00d, 6'd0);
      tick("commit data");
      clear_requests();
      tick("commit data");
      put_commit(1, 5'd7, 32'h1111_2222, 6'd0);
      put_commit(2, 5'd7, 32'h3333_4444, 6'd0);
      tick("commit same reg");
      clear_requests();
      tick("commit same reg");
      // dispatch
      set_sources(5'd9, 5'd10, 5'd9, 5'd10);
      put_rename(1, 5'd9, 6'h11);
      tick("dispatch");
      clear_requests();
      tick("dispatch");
      put_rename(1, 5'd10, 6'h03);
      put_rename(2, 5'd10, 6'h04);
      tick("dispatch same reg");
      clear_requests();
      tick("dispatch same reg");
      // reg 9 tag matches, reg 10 is stale
      put_commit(1, 5'd9, 32'h5555_aaaa, 6'h11);
      put_commit(2, 5'd10, 32'h7777_8888, 6'h03);
      tick("tag clear");
      clear_requests();
      tick("tag clear");
      // matching commit and rename on one reg
      put_commit(1, 5'd10, 32'h9999_0000, 6'h04);
      put_rename(1, 5'd10, 6'h2a);
      tick("set over clear");
      clear_requests();
      tick("set over clear");
      random_traffic(2000);
      clear_requests();
      tick("random traffic");
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hw/arf_pkg.sv
hw/reg_array.sv
hw/commit_unit.sv
hw/busy_vector.sv
hw/arf_top.sv
sim/arf_tb.sv
